/* project.f */
+incdir+.
isa_pkg.sv
scb_pkg.sv
scb_dispatch.sv
scb_slot_table.sv
scb_raw_check.sv
scb_wb_arbiter.sv
scb_top.sv
tb_scb_top.sv

/* tb_scb_top.sv */
`timescale 1ns/1ps
`include "scb_config.svh"

module tb_scb_top;

    localparam int NS = `SCB_NUM_SLOTS;
    localparam int SW = `SCB_SID_WIDTH;

    typedef logic [SW-1:0]                 sid_t;
    typedef logic [`SCB_REG_IDX_WIDTH-1:0] idx_t;
    typedef logic [`SCB_EXE_UNIT_WIDTH-1:0] unit_t;

    // one table row: all inputs for one cycle
    typedef struct packed {
        logic [1:0]        dv;
        unit_t [1:0]       du;
        idx_t [1:0]        drd;
        idx_t [1:0]        drs1;
        idx_t [1:0]        drs2;
        logic [1:0]        ov;
        sid_t [1:0]        osid;
        idx_t [1:0]        ord;
        idx_t [1:0]        ors1;
        idx_t [1:0]        ors2;
        logic [1:0]        wv;
        sid_t [1:0]        wsid;
        idx_t [1:0]        wrd;
        logic              redir;
        sid_t              rsid;
    } step_t;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic d0_vld, d1_vld, o0_vld, o1_vld, w0_vld, w1_vld, redir;
    unit_t d0_unit, d1_unit;
    idx_t d0_rd, d0_rs1, d0_rs2, d1_rd, d1_rs1, d1_rs2;
    idx_t o0_rd, o0_rs1, o0_rs2, o1_rd, o1_rs1, o1_rs2, w0_rd, w1_rd;
    sid_t o0_sid, o1_sid, w0_sid, w1_sid, redir_sid;
    logic st_d0, st_d1, fl_d0, fl_d1, st_o0, st_o1, fl_o0, fl_o1;
    logic st_w0, st_w1, fl_w0, fl_w1;
    sid_t sid0, sid1;
    logic [NS-1:0] mask0, mask1;

    step_t    steps[$];
    string    names[$];
    step_t    st;
    logic [31:0] rng = 32'h1e232826;
    int       errors = 0;
    int       checks = 0;
    int       cycles = 0;
    int       limit = 100000;

    // model of the slots and the sid counter
    logic [NS-1:0] m_busy;
    idx_t [NS-1:0] m_rd;
    sid_t [NS-1:0] m_sid;
    sid_t          m_cur;
    logic [1:0]    e_dst, e_dfl, e_ost, e_ofl, e_wst, e_wfl;
    logic [NS-1:0] e_wr0, e_wr1, e_rel;

    scb_top uut (
        .clk(clk), .rst_n(rst_n),
        .decoder_inst0_vld_i(d0_vld), .decoder_inst0_exe_unit_i(d0_unit),
        .decoder_inst0_rd_i(d0_rd), .decoder_inst0_rs1_i(d0_rs1), .decoder_inst0_rs2_i(d0_rs2),
        .decoder_inst1_vld_i(d1_vld), .decoder_inst1_exe_unit_i(d1_unit),
        .decoder_inst1_rd_i(d1_rd), .decoder_inst1_rs1_i(d1_rs1), .decoder_inst1_rs2_i(d1_rs2),
        .stall_decoder_inst0_o(st_d0), .stall_decoder_inst1_o(st_d1),
        .flush_decoder_inst0_o(fl_d0), .flush_decoder_inst1_o(fl_d1),
        .decoder_inst0_sid_o(sid0), .decoder_inst1_sid_o(sid1),
        .decoder_inst0_h_exe_unit_o(mask0), .decoder_inst1_h_exe_unit_o(mask1),
        .op_inst0_vld_i(o0_vld), .op_inst0_sid_i(o0_sid), .op_inst0_rd_i(o0_rd),
        .op_inst0_rs1_i(o0_rs1), .op_inst0_rs2_i(o0_rs2),
        .op_inst1_vld_i(o1_vld), .op_inst1_sid_i(o1_sid), .op_inst1_rd_i(o1_rd),
        .op_inst1_rs1_i(o1_rs1), .op_inst1_rs2_i(o1_rs2),
        .op_stall_inst0_o(st_o0), .op_stall_inst1_o(st_o1),
        .op_flush_inst0_o(fl_o0), .op_flush_inst1_o(fl_o1),
        .wb_inst0_vld_i(w0_vld), .wb_inst0_sid_i(w0_sid), .wb_inst0_rd_i(w0_rd),
        .wb_inst1_vld_i(w1_vld), .wb_inst1_sid_i(w1_sid), .wb_inst1_rd_i(w1_rd),
        .wb_redirect_i(redir), .wb_redirect_sid_i(redir_sid),
        .wb_stall_inst0_o(st_w0), .wb_stall_inst1_o(st_w1),
        .wb_flush_inst0_o(fl_w0), .wb_flush_inst1_o(fl_w1)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // larger index is younger unless the wrap bits differ
    function automatic logic is_younger(sid_t a, sid_t b);
        if (a[SW-1] == b[SW-1])
            return a[SW-2:0] > b[SW-2:0];
        return a[SW-2:0] < b[SW-2:0];
    endfunction

    function automatic unit_t unit_bit(int pos);
        return unit_t'(1) << pos;
    endfunction

    function automatic logic [NS-1:0] choose_slot(logic v, unit_t u, logic [NS-1:0] free);
        logic [NS-1:0] p;
        p = '0;
        if (v && u[isa_pkg::EXE_ALU]) begin
            if (free[scb_pkg::SLOT_ALU0])
                p[scb_pkg::SLOT_ALU0] = 1'b1;
            else if (free[scb_pkg::SLOT_ALU1])
                p[scb_pkg::SLOT_ALU1] = 1'b1;
        end else if (v && u[isa_pkg::EXE_BEU]) begin
            p[scb_pkg::SLOT_BEU] = free[scb_pkg::SLOT_BEU];
        end else if (v && u[isa_pkg::EXE_LSU]) begin
            p[scb_pkg::SLOT_LSU] = free[scb_pkg::SLOT_LSU];
        end
        return p;
    endfunction

    task automatic compute_expect(input step_t s);
        logic [NS-1:0] p0, p1;
        logic [1:0] waw, go;
        logic pair;
        sid_t dsid [2];
        dsid[0] = m_cur;
        dsid[1] = m_cur + 1'b1;
        e_ost = '0;
        waw = '0;
        for (int l = 0; l < 2; l++) begin
            for (int k = 0; k < NS; k++) begin
                if (m_busy[k] && is_younger(s.osid[l], m_sid[k]) &&
                    (m_rd[k] == s.ors1[l] || m_rd[k] == s.ors2[l]))
                    e_ost[l] = s.ov[l];
                if (m_busy[k] && m_rd[k] == s.drd[l])
                    waw[l] = 1'b1;
            end
            if (s.ov[1-l] && is_younger(s.osid[l], s.osid[1-l]) &&
                (s.ord[1-l] == s.ors1[l] || s.ord[1-l] == s.ors2[l]))
                e_ost[l] = s.ov[l];
            e_ofl[l] = s.redir && is_younger(s.osid[l], s.rsid);
            e_dfl[l] = s.redir && is_younger(dsid[l], s.rsid);
            e_wfl[l] = s.redir && is_younger(s.wsid[l], s.rsid);
        end
        p0 = choose_slot(s.dv[0], s.du[0], ~m_busy);
        p1 = choose_slot(s.dv[1], s.du[1], ~m_busy & ~p0);
        pair = s.dv[0] && s.drd[0] == s.drd[1];
        e_dst[0] = s.dv[0] && (p0 == '0 || waw[0] || e_ost[0]);
        e_dst[1] = s.dv[1] && (p1 == '0 || waw[1] || e_ost[1] || pair || e_dst[0]);
        e_wr0 = (s.dv[0] && !e_dst[0]) ? p0 : '0;
        e_wr1 = (s.dv[1] && !e_dst[1]) ? p1 : '0;
        e_wst = '0;
        if (s.wv == 2'b11 && s.wrd[0] == s.wrd[1]) begin
            e_wst[0] = is_younger(s.wsid[0], s.wsid[1]);
            e_wst[1] = is_younger(s.wsid[1], s.wsid[0]);
        end
        go = s.wv & ~e_wst;
        for (int k = 0; k < NS; k++)
            e_rel[k] = m_busy[k] && ((go[0] && s.wsid[0] == m_sid[k]) ||
                                     (go[1] && s.wsid[1] == m_sid[k]));
    endtask

    task automatic update_model(input step_t s);
        for (int k = 0; k < NS; k++) begin
            if (m_busy[k] && s.redir && is_younger(m_sid[k], s.rsid)) begin
                m_busy[k] = 1'b0;
            end else if (e_wr0[k]) begin
                m_busy[k] = 1'b1;
                m_rd[k] = s.drd[0];
                m_sid[k] = m_cur;
            end else if (e_wr1[k]) begin
                m_busy[k] = 1'b1;
                m_rd[k] = s.drd[1];
                m_sid[k] = m_cur + 1'b1;
            end else if (e_rel[k]) begin
                m_busy[k] = 1'b0;
            end
        end
        m_cur = m_cur + sid_t'(|e_wr0) + sid_t'(|e_wr1);
    endtask

    task automatic drive(input step_t s);
        {d1_vld, d0_vld} = s.dv;
        {d1_unit, d0_unit} = s.du;
        {d1_rd, d0_rd} = s.drd;
        {d1_rs1, d0_rs1} = s.drs1;
        {d1_rs2, d0_rs2} = s.drs2;
        {o1_vld, o0_vld} = s.ov;
        {o1_sid, o0_sid} = s.osid;
        {o1_rd, o0_rd} = s.ord;
        {o1_rs1, o0_rs1} = s.ors1;
        {o1_rs2, o0_rs2} = s.ors2;
        {w1_vld, w0_vld} = s.wv;
        {w1_sid, w0_sid} = s.wsid;
        {w1_rd, w0_rd} = s.wrd;
        redir = s.redir;
        redir_sid = s.rsid;
    endtask

    task automatic check_val(input string step, input string sig,
                             input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s %s expected %h actual %h", step, sig, exp, act);
        end
    endtask

    task automatic set_dec(int l, int unit, int rd, int rs1, int rs2);
        st.dv[l] = 1'b1;
        st.du[l] = unit_bit(unit);
        st.drd[l] = idx_t'(rd);
        st.drs1[l] = idx_t'(rs1);
        st.drs2[l] = idx_t'(rs2);
    endtask

    task automatic set_op(int l, int sid, int rd, int rs1, int rs2);
        st.ov[l] = 1'b1;
        st.osid[l] = sid_t'(sid);
        st.ord[l] = idx_t'(rd);
        st.ors1[l] = idx_t'(rs1);
        st.ors2[l] = idx_t'(rs2);
    endtask

    task automatic set_wb(int l, logic v, int sid, int rd);
        st.wv[l] = v;
        st.wsid[l] = sid_t'(sid);
        st.wrd[l] = idx_t'(rd);
    endtask

    task automatic push(input string name);
        steps.push_back(st);
        names.push_back(name);
        st = '0;
    endtask

    task automatic build_table();
        int u;
        st = '0;
        set_dec(0, isa_pkg::EXE_ALU, 1, 0, 0);
        set_dec(1, isa_pkg::EXE_LSU, 2, 1, 0);
        push("pair_alu_lsu");
        set_dec(0, isa_pkg::EXE_ALU, 3, 0, 0);
        set_dec(1, isa_pkg::EXE_BEU, 4, 0, 0);
        push("pair_alu_beu");
        set_dec(0, isa_pkg::EXE_ALU, 5, 0, 0);
        set_wb(0, 1'b1, 0, 1);
        push("alu_full");
        // alu0 is free again, so only the busy lsu rd can stall this
        set_dec(0, isa_pkg::EXE_ALU, 2, 0, 0);
        set_wb(0, 1'b1, 1, 2);
        push("waw_busy_rd");
        set_dec(0, isa_pkg::EXE_ALU, 6, 0, 0);
        set_dec(1, isa_pkg::EXE_LSU, 6, 0, 0);
        push("pair_same_rd");
        set_dec(0, isa_pkg::EXE_BEU, 7, 0, 0);
        set_wb(1, 1'b1, 3, 4);
        push("beu_busy_release");
        set_dec(0, isa_pkg::EXE_ALU, 9, 0, 0);
        set_dec(1, isa_pkg::EXE_LSU, 10, 0, 0);
        push("inst1_follows_inst0");
        set_op(0, 5, 20, 3, 0);
        set_op(1, 1, 21, 6, 0);
        set_dec(0, isa_pkg::EXE_LSU, 11, 0, 0);
        set_dec(1, isa_pkg::EXE_BEU, 12, 0, 0);
        push("op_raw_slot");
        set_op(0, 5, 13, 0, 0);
        set_op(1, 6, 22, 13, 0);
        set_dec(0, isa_pkg::EXE_LSU, 11, 0, 0);
        set_dec(1, isa_pkg::EXE_BEU, 12, 0, 0);
        push("op_pair_raw");
        set_wb(0, 1'b1, 4, 6);
        set_wb(1, 1'b1, 2, 6);
        push("wb_same_rd");
        set_dec(0, isa_pkg::EXE_ALU, 14, 0, 0);
        push("dispatch_after_wb");
        st.redir = 1'b1;
        st.rsid = sid_t'(4);
        set_op(0, 5, 0, 0, 0);
        set_op(1, 3, 0, 0, 0);
        set_wb(0, 1'b0, 9, 0);
        set_wb(1, 1'b0, 1, 0);
        push("redirect");
        set_dec(0, isa_pkg::EXE_ALU, 14, 0, 0);
        set_dec(1, isa_pkg::EXE_LSU, 15, 0, 0);
        set_op(0, 7, 0, 11, 14);
        push("after_flush");
        st.redir = 1'b1;
        st.rsid = sid_t'(7);
        set_op(0, 9, 0, 0, 0);
        set_op(1, 6, 0, 0, 0);
        push("redirect_wrap");
        set_dec(0, isa_pkg::EXE_LSU, 15, 0, 0);
        set_op(0, 9, 0, 15, 0);
        push("lsu_after_wrap_flush");
        for (int i = 0; i < 12; i++) begin
            for (int l = 0; l < 2; l++) begin
                u = next_rand() % 3;
                if (next_rand() % 4 != 0)
                    set_dec(l, u, next_rand() % 32, next_rand() % 32, next_rand() % 32);
                if (next_rand() % 2 != 0)
                    set_op(l, next_rand() % 16, next_rand() % 32,
                           next_rand() % 32, next_rand() % 32);
                set_wb(l, next_rand() % 2, next_rand() % 16, next_rand() % 32);
            end
            st.redir = (next_rand() % 8 == 0);
            st.rsid = sid_t'(next_rand() % 16);
            push($sformatf("filler_%0d", i));
        end
    endtask

    initial begin
        st = '0;
        drive(st);
        m_busy = '0;
        m_rd = '0;
        m_sid = '0;
        m_cur = '0;
        build_table();
        limit = steps.size() + 16 + 20;
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clk);
            #2;
            drive(steps[i]);
            compute_expect(steps[i]);
            #16;
            check_val(names[i], "stall_decoder", 8'(e_dst), 8'({st_d1, st_d0}));
            check_val(names[i], "flush_decoder", 8'(e_dfl), 8'({fl_d1, fl_d0}));
            check_val(names[i], "inst0_sid", 8'(m_cur), 8'(sid0));
            check_val(names[i], "inst1_sid", 8'(sid_t'(m_cur + 1'b1)), 8'(sid1));
            check_val(names[i], "inst0_mask", 8'(e_wr0), 8'(mask0));
            check_val(names[i], "inst1_mask", 8'(e_wr1), 8'(mask1));
            check_val(names[i], "op_stall", 8'(e_ost), 8'({st_o1, st_o0}));
            check_val(names[i], "op_flush", 8'(e_ofl), 8'({fl_o1, fl_o0}));
            check_val(names[i], "wb_stall", 8'(e_wst), 8'({st_w1, st_w0}));
            check_val(names[i], "wb_flush", 8'(e_wfl), 8'({fl_w1, fl_w0}));
            update_model(steps[i]);
        end
        $display("errors: %0d of %0d checks over %0d steps", errors, checks, steps.size());
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* scb_top.sv */
`timescale 1ns/1ps
`include "scb_config.svh"

module scb_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           decoder_inst0_vld_i,
    input  logic [`SCB_EXE_UNIT_WIDTH-1:0] decoder_inst0_exe_unit_i,
    input  isa_pkg::reg_idx_t              decoder_inst0_rd_i,
    input  isa_pkg::reg_idx_t              decoder_inst0_rs1_i,
    input  isa_pkg::reg_idx_t              decoder_inst0_rs2_i,
    input  logic                           decoder_inst1_vld_i,
    input  logic [`SCB_EXE_UNIT_WIDTH-1:0] decoder_inst1_exe_unit_i,
    input  isa_pkg::reg_idx_t              decoder_inst1_rd_i,
    input  isa_pkg::reg_idx_t              decoder_inst1_rs1_i,
    input  isa_pkg::reg_idx_t              decoder_inst1_rs2_i,
    output logic                           stall_decoder_inst0_o,
    output logic                           stall_decoder_inst1_o,
    output logic                           flush_decoder_inst0_o,
    output logic                           flush_decoder_inst1_o,
    output scb_pkg::sid_t                  decoder_inst0_sid_o,
    output scb_pkg::sid_t                  decoder_inst1_sid_o,
    output logic [`SCB_NUM_SLOTS-1:0]      decoder_inst0_h_exe_unit_o,
    output logic [`SCB_NUM_SLOTS-1:0]      decoder_inst1_h_exe_unit_o,
    input  logic                           op_inst0_vld_i,
    input  scb_pkg::sid_t                  op_inst0_sid_i,
    input  isa_pkg::reg_idx_t              op_inst0_rd_i,
    input  isa_pkg::reg_idx_t              op_inst0_rs1_i,
    input  isa_pkg::reg_idx_t              op_inst0_rs2_i,
    input  logic                           op_inst1_vld_i,
    input  scb_pkg::sid_t                  op_inst1_sid_i,
    input  isa_pkg::reg_idx_t              op_inst1_rd_i,
    input  isa_pkg::reg_idx_t              op_inst1_rs1_i,
    input  isa_pkg::reg_idx_t              op_inst1_rs2_i,
    output logic                           op_stall_inst0_o,
    output logic                           op_stall_inst1_o,
    output logic                           op_flush_inst0_o,
    output logic                           op_flush_inst1_o,
    input  logic                           wb_inst0_vld_i,
    input  scb_pkg::sid_t                  wb_inst0_sid_i,
    input  isa_pkg::reg_idx_t              wb_inst0_rd_i,
    input  logic                           wb_inst1_vld_i,
    input  scb_pkg::sid_t                  wb_inst1_sid_i,
    input  isa_pkg::reg_idx_t              wb_inst1_rd_i,
    input  logic                           wb_redirect_i,
    input  scb_pkg::sid_t                  wb_redirect_sid_i,
    output logic                           wb_stall_inst0_o,
    output logic                           wb_stall_inst1_o,
    output logic                           wb_flush_inst0_o,
    output logic                           wb_flush_inst1_o
);

    logic [`SCB_NUM_SLOTS-1:0]              slot_busy;
    logic [`SCB_NUM_SLOTS-1:0]              slot_wr_inst0;
    logic [`SCB_NUM_SLOTS-1:0]              slot_wr_inst1;
    logic [`SCB_NUM_SLOTS-1:0]              slot_release;
    isa_pkg::reg_idx_t [`SCB_NUM_SLOTS-1:0] slot_rd;
    scb_pkg::sid_t [`SCB_NUM_SLOTS-1:0]     slot_sid;

    scb_dispatch u_dispatch (
        .op_stall_inst0_i (op_stall_inst0_o),
        .op_stall_inst1_i (op_stall_inst1_o),
        .slot_busy_i      (slot_busy),
        .slot_rd_i        (slot_rd),
        .slot_wr_inst0_o  (slot_wr_inst0),
        .slot_wr_inst1_o  (slot_wr_inst1),
        .*
    );

    // source operands are kept per slot but no stage reads them back yet
    scb_slot_table u_slot_table (
        .slot_wr_inst0_i (slot_wr_inst0),
        .slot_wr_inst1_i (slot_wr_inst1),
        .inst0_sid_i     (decoder_inst0_sid_o),
        .inst1_sid_i     (decoder_inst1_sid_o),
        .slot_release_i  (slot_release),
        .slot_busy_o     (slot_busy),
        .slot_rd_o       (slot_rd),
        .slot_rs1_o      (),
        .slot_rs2_o      (),
        .slot_sid_o      (slot_sid),
        .*
    );

    scb_raw_check u_raw_check (
        .slot_busy_i (slot_busy),
        .slot_rd_i   (slot_rd),
        .slot_sid_i  (slot_sid),
        .*
    );

    scb_wb_arbiter u_wb_arbiter (
        .slot_busy_i    (slot_busy),
        .slot_sid_i     (slot_sid),
        .slot_release_o (slot_release),
        .*
    );

endmodule

/* scb_wb_arbiter.sv */
`timescale 1ns/1ps
`include "scb_config.svh"

module scb_wb_arbiter (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               wb_inst0_vld_i,
    input  scb_pkg::sid_t                      wb_inst0_sid_i,
    input  isa_pkg::reg_idx_t                  wb_inst0_rd_i,
    input  logic                               wb_inst1_vld_i,
    input  scb_pkg::sid_t                      wb_inst1_sid_i,
    input  isa_pkg::reg_idx_t                  wb_inst1_rd_i,
    input  logic [`SCB_NUM_SLOTS-1:0]          slot_busy_i,
    input  scb_pkg::sid_t [`SCB_NUM_SLOTS-1:0] slot_sid_i,
    input  logic                               wb_redirect_i,
    input  scb_pkg::sid_t                      wb_redirect_sid_i,
    output logic                               wb_stall_inst0_o,
    output logic                               wb_stall_inst1_o,
    output logic                               wb_flush_inst0_o,
    output logic                               wb_flush_inst1_o,
    output logic [`SCB_NUM_SLOTS-1:0]          slot_release_o
);

    logic same_rd;
    logic inst0_go;
    logic inst1_go;

    assign same_rd = wb_inst0_vld_i && wb_inst1_vld_i && wb_inst0_rd_i == wb_inst1_rd_i;

    // younger writer waits a cycle
    assign wb_stall_inst0_o = same_rd && scb_pkg::sid_younger(wb_inst0_sid_i, wb_inst1_sid_i);
    assign wb_stall_inst1_o = same_rd && scb_pkg::sid_younger(wb_inst1_sid_i, wb_inst0_sid_i);

    assign inst0_go = wb_inst0_vld_i && !wb_stall_inst0_o;
    assign inst1_go = wb_inst1_vld_i && !wb_stall_inst1_o;

    always_comb begin
        for (int s = 0; s < `SCB_NUM_SLOTS; s++)
            slot_release_o[s] = slot_busy_i[s] &&
                                ((inst0_go && wb_inst0_sid_i == slot_sid_i[s]) ||
                                 (inst1_go && wb_inst1_sid_i == slot_sid_i[s]));
    end

    assign wb_flush_inst0_o = scb_pkg::sid_flushed(wb_redirect_i, wb_redirect_sid_i,
                                                   wb_inst0_sid_i);
    assign wb_flush_inst1_o = scb_pkg::sid_flushed(wb_redirect_i, wb_redirect_sid_i,
                                                   wb_inst1_sid_i);

    a_one_wb_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_stall_inst0_o && wb_stall_inst1_o));

endmodule

/* scb_raw_check.sv */
`timescale 1ns/1ps
`include "scb_config.svh"

module scb_raw_check (
    input  logic                                   op_inst0_vld_i,
    input  scb_pkg::sid_t                          op_inst0_sid_i,
    input  isa_pkg::reg_idx_t                      op_inst0_rd_i,
    input  isa_pkg::reg_idx_t                      op_inst0_rs1_i,
    input  isa_pkg::reg_idx_t                      op_inst0_rs2_i,
    input  logic                                   op_inst1_vld_i,
    input  scb_pkg::sid_t                          op_inst1_sid_i,
    input  isa_pkg::reg_idx_t                      op_inst1_rd_i,
    input  isa_pkg::reg_idx_t                      op_inst1_rs1_i,
    input  isa_pkg::reg_idx_t                      op_inst1_rs2_i,
    input  logic [`SCB_NUM_SLOTS-1:0]              slot_busy_i,
    input  isa_pkg::reg_idx_t [`SCB_NUM_SLOTS-1:0] slot_rd_i,
    input  scb_pkg::sid_t [`SCB_NUM_SLOTS-1:0]     slot_sid_i,
    input  logic                                   wb_redirect_i,
    input  scb_pkg::sid_t                          wb_redirect_sid_i,
    output logic                                   op_stall_inst0_o,
    output logic                                   op_stall_inst1_o,
    output logic                                   op_flush_inst0_o,
    output logic                                   op_flush_inst1_o
);

    // lane 0 and lane 1 side by side
    logic [1:0]                  vld;
    scb_pkg::sid_t [1:0]         sid;
    isa_pkg::reg_idx_t [1:0]     rd;
    isa_pkg::reg_idx_t [1:0]     rs1;
    isa_pkg::reg_idx_t [1:0]     rs2;
    logic [1:0]                  raw;

    assign vld = {op_inst1_vld_i, op_inst0_vld_i};
    assign sid = {op_inst1_sid_i, op_inst0_sid_i};
    assign rd  = {op_inst1_rd_i, op_inst0_rd_i};
    assign rs1 = {op_inst1_rs1_i, op_inst0_rs1_i};
    assign rs2 = {op_inst1_rs2_i, op_inst0_rs2_i};

    always_comb begin
        raw = '0;
        for (int l = 0; l < 2; l++) begin
            // older producer still in flight
            for (int s = 0; s < `SCB_NUM_SLOTS; s++) begin
                if (slot_busy_i[s] && scb_pkg::sid_younger(sid[l], slot_sid_i[s]) &&
                    (slot_rd_i[s] == rs1[l] || slot_rd_i[s] == rs2[l]))
                    raw[l] = 1'b1;
            end
            // older partner in the operand stage
            if (vld[1-l] && scb_pkg::sid_younger(sid[l], sid[1-l]) &&
                (rd[1-l] == rs1[l] || rd[1-l] == rs2[l]))
                raw[l] = 1'b1;
        end
    end

    assign op_stall_inst0_o = vld[0] && raw[0];
    assign op_stall_inst1_o = vld[1] && raw[1];

    assign op_flush_inst0_o = scb_pkg::sid_flushed(wb_redirect_i, wb_redirect_sid_i, sid[0]);
    assign op_flush_inst1_o = scb_pkg::sid_flushed(wb_redirect_i, wb_redirect_sid_i, sid[1]);

endmodule

/* scb_slot_table.sv */
`timescale 1ns/1ps
`include "scb_config.svh"

module scb_slot_table (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  isa_pkg::reg_idx_t                      decoder_inst0_rd_i,
    input  isa_pkg::reg_idx_t                      decoder_inst0_rs1_i,
    input  isa_pkg::reg_idx_t                      decoder_inst0_rs2_i,
    input  isa_pkg::reg_idx_t                      decoder_inst1_rd_i,
    input  isa_pkg::reg_idx_t                      decoder_inst1_rs1_i,
    input  isa_pkg::reg_idx_t                      decoder_inst1_rs2_i,
    input  logic [`SCB_NUM_SLOTS-1:0]              slot_wr_inst0_i,
    input  logic [`SCB_NUM_SLOTS-1:0]              slot_wr_inst1_i,
    input  scb_pkg::sid_t                          inst0_sid_i,
    input  scb_pkg::sid_t                          inst1_sid_i,
    input  logic [`SCB_NUM_SLOTS-1:0]              slot_release_i,
    input  logic                                   wb_redirect_i,
    input  scb_pkg::sid_t                          wb_redirect_sid_i,
    output logic [`SCB_NUM_SLOTS-1:0]              slot_busy_o,
    output isa_pkg::reg_idx_t [`SCB_NUM_SLOTS-1:0] slot_rd_o,
    output isa_pkg::reg_idx_t [`SCB_NUM_SLOTS-1:0] slot_rs1_o,
    output isa_pkg::reg_idx_t [`SCB_NUM_SLOTS-1:0] slot_rs2_o,
    output scb_pkg::sid_t [`SCB_NUM_SLOTS-1:0]     slot_sid_o
);

    logic [`SCB_NUM_SLOTS-1:0] flush;

    // only occupied slots can be flushed
    always_comb begin
        for (int s = 0; s < `SCB_NUM_SLOTS; s++)
            flush[s] = slot_busy_o[s] &&
                       scb_pkg::sid_flushed(wb_redirect_i, wb_redirect_sid_i, slot_sid_o[s]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_busy_o <= '0;
        end else begin
            for (int s = 0; s < `SCB_NUM_SLOTS; s++) begin
                if (flush[s])
                    slot_busy_o[s] <= 1'b0;
                else if (slot_wr_inst0_i[s] || slot_wr_inst1_i[s])
                    slot_busy_o[s] <= 1'b1;
                else if (slot_release_i[s])
                    slot_busy_o[s] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < `SCB_NUM_SLOTS; s++) begin
            if (slot_wr_inst0_i[s]) begin
                slot_rd_o[s]  <= decoder_inst0_rd_i;
                slot_rs1_o[s] <= decoder_inst0_rs1_i;
                slot_rs2_o[s] <= decoder_inst0_rs2_i;
                slot_sid_o[s] <= inst0_sid_i;
            end else if (slot_wr_inst1_i[s]) begin
                slot_rd_o[s]  <= decoder_inst1_rd_i;
                slot_rs1_o[s] <= decoder_inst1_rs1_i;
                slot_rs2_o[s] <= decoder_inst1_rs2_i;
                slot_sid_o[s] <= inst1_sid_i;
            end
        end
    end

    a_wr_free_slot: assert property (@(posedge clk) disable iff (!rst_n)
        ((slot_wr_inst0_i | slot_wr_inst1_i) & slot_busy_o) == '0);

endmodule

/* scb_dispatch.sv */
`timescale 1ns/1ps
`include "scb_config.svh"

module scb_dispatch (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   decoder_inst0_vld_i,
    input  logic [`SCB_EXE_UNIT_WIDTH-1:0]         decoder_inst0_exe_unit_i,
    input  isa_pkg::reg_idx_t                      decoder_inst0_rd_i,
    input  logic                                   decoder_inst1_vld_i,
    input  logic [`SCB_EXE_UNIT_WIDTH-1:0]         decoder_inst1_exe_unit_i,
    input  isa_pkg::reg_idx_t                      decoder_inst1_rd_i,
    input  logic                                   op_stall_inst0_i,
    input  logic                                   op_stall_inst1_i,
    input  logic [`SCB_NUM_SLOTS-1:0]              slot_busy_i,
    input  isa_pkg::reg_idx_t [`SCB_NUM_SLOTS-1:0] slot_rd_i,
    input  logic                                   wb_redirect_i,
    input  scb_pkg::sid_t                          wb_redirect_sid_i,
    output logic                                   stall_decoder_inst0_o,
    output logic                                   stall_decoder_inst1_o,
    output logic                                   flush_decoder_inst0_o,
    output logic                                   flush_decoder_inst1_o,
    output scb_pkg::sid_t                          decoder_inst0_sid_o,
    output scb_pkg::sid_t                          decoder_inst1_sid_o,
    output logic [`SCB_NUM_SLOTS-1:0]              decoder_inst0_h_exe_unit_o,
    output logic [`SCB_NUM_SLOTS-1:0]              decoder_inst1_h_exe_unit_o,
    output logic [`SCB_NUM_SLOTS-1:0]              slot_wr_inst0_o,
    output logic [`SCB_NUM_SLOTS-1:0]              slot_wr_inst1_o
);

    scb_pkg::sid_t             cur_sid_r;
    logic [`SCB_NUM_SLOTS-1:0] inst0_pick;
    logic [`SCB_NUM_SLOTS-1:0] inst1_pick;
    logic                      inst0_waw;
    logic                      inst1_waw;
    logic                      pair_waw;
    logic                      inst0_acc;
    logic                      inst1_acc;

    // alu0 first, then alu1; beu and lsu have one slot each
    function automatic logic [`SCB_NUM_SLOTS-1:0] pick_slot(
        input logic                           vld,
        input logic [`SCB_EXE_UNIT_WIDTH-1:0] unit,
        input logic [`SCB_NUM_SLOTS-1:0]      free
    );
        logic [`SCB_NUM_SLOTS-1:0] pick;
        pick = '0;
        if (vld && unit[isa_pkg::EXE_ALU]) begin
            if (free[scb_pkg::SLOT_ALU0])
                pick[scb_pkg::SLOT_ALU0] = 1'b1;
            else if (free[scb_pkg::SLOT_ALU1])
                pick[scb_pkg::SLOT_ALU1] = 1'b1;
        end else if (vld && unit[isa_pkg::EXE_BEU]) begin
            pick[scb_pkg::SLOT_BEU] = free[scb_pkg::SLOT_BEU];
        end else if (vld && unit[isa_pkg::EXE_LSU]) begin
            pick[scb_pkg::SLOT_LSU] = free[scb_pkg::SLOT_LSU];
        end
        return pick;
    endfunction

    assign inst0_pick = pick_slot(decoder_inst0_vld_i, decoder_inst0_exe_unit_i, ~slot_busy_i);
    // inst1 skips whatever inst0 takes this cycle
    assign inst1_pick = pick_slot(decoder_inst1_vld_i, decoder_inst1_exe_unit_i,
                                  ~slot_busy_i & ~inst0_pick);

    always_comb begin
        inst0_waw = 1'b0;
        inst1_waw = 1'b0;
        for (int s = 0; s < `SCB_NUM_SLOTS; s++) begin
            if (slot_busy_i[s] && slot_rd_i[s] == decoder_inst0_rd_i)
                inst0_waw = 1'b1;
            if (slot_busy_i[s] && slot_rd_i[s] == decoder_inst1_rd_i)
                inst1_waw = 1'b1;
        end
    end

    assign pair_waw = decoder_inst0_vld_i && decoder_inst0_rd_i == decoder_inst1_rd_i;

    assign stall_decoder_inst0_o = decoder_inst0_vld_i &&
                                   (!(|inst0_pick) || inst0_waw || op_stall_inst0_i);
    assign stall_decoder_inst1_o = decoder_inst1_vld_i &&
                                   (!(|inst1_pick) || inst1_waw || op_stall_inst1_i ||
                                    pair_waw || stall_decoder_inst0_o);

    assign inst0_acc = decoder_inst0_vld_i && !stall_decoder_inst0_o;
    assign inst1_acc = decoder_inst1_vld_i && !stall_decoder_inst1_o;

    assign slot_wr_inst0_o = inst0_pick & {`SCB_NUM_SLOTS{inst0_acc}};
    assign slot_wr_inst1_o = inst1_pick & {`SCB_NUM_SLOTS{inst1_acc}};
    assign decoder_inst0_h_exe_unit_o = slot_wr_inst0_o;
    assign decoder_inst1_h_exe_unit_o = slot_wr_inst1_o;

    assign decoder_inst0_sid_o = cur_sid_r;
    assign decoder_inst1_sid_o = cur_sid_r + 1'b1;

    assign flush_decoder_inst0_o = scb_pkg::sid_flushed(wb_redirect_i, wb_redirect_sid_i,
                                                        decoder_inst0_sid_o);
    assign flush_decoder_inst1_o = scb_pkg::sid_flushed(wb_redirect_i, wb_redirect_sid_i,
                                                        decoder_inst1_sid_o);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cur_sid_r <= '0;
        else
            cur_sid_r <= cur_sid_r + scb_pkg::sid_t'(inst0_acc) + scb_pkg::sid_t'(inst1_acc);
    end

    a_no_double_place: assert property (@(posedge clk) disable iff (!rst_n)
        (slot_wr_inst0_o & slot_wr_inst1_o) == '0);

endmodule

/* scb_pkg.sv */
`include "scb_config.svh"

package scb_pkg;

    typedef logic [`SCB_SID_WIDTH-1:0] sid_t;

    // bit order of every per-slot vector
    typedef enum logic [1:0] {
        SLOT_ALU0 = 2'd0,
        SLOT_ALU1 = 2'd1,
        SLOT_BEU  = 2'd2,
        SLOT_LSU  = 2'd3
    } slot_e;

    // true when a is younger than b with the msb as wrap bit
    function automatic logic sid_younger(input sid_t a, input sid_t b);
        if (a[`SCB_SID_WIDTH-1] == b[`SCB_SID_WIDTH-1])
            return a[`SCB_SID_WIDTH-2:0] > b[`SCB_SID_WIDTH-2:0];
        return a[`SCB_SID_WIDTH-2:0] < b[`SCB_SID_WIDTH-2:0];
    endfunction

    function automatic logic sid_flushed(input logic redirect, input sid_t redirect_sid,
                                         input sid_t sid);
        return redirect && sid_younger(sid, redirect_sid);
    endfunction

endpackage

/* isa_pkg.sv */
`include "scb_config.svh"

package isa_pkg;

    typedef logic [`SCB_REG_IDX_WIDTH-1:0] reg_idx_t;

    // values are bit positions in the decoder unit mask
    typedef enum int {
        EXE_ALU = `SCB_UNIT_ALU,
        EXE_BEU = `SCB_UNIT_BEU,
        EXE_LSU = `SCB_UNIT_LSU
    } exe_unit_e;

endpackage

/* scb_config.svh */
`ifndef SCB_CONFIG_SVH
`define SCB_CONFIG_SVH

// sid index plus one wrap bit
`define SCB_SID_WIDTH       4
`define SCB_REG_IDX_WIDTH   5
`define SCB_EXE_UNIT_WIDTH  6

// bit positions in the decoder unit-class mask
`define SCB_UNIT_ALU        0
`define SCB_UNIT_BEU        1
`define SCB_UNIT_LSU        2

// alu0, alu1, beu, lsu
`define SCB_NUM_SLOTS       4

`endif
